/* segre_core.f */
hdl/segre_pkg.sv
hdl/segre_mem_pkg.sv
hdl/segre_controller.sv
hdl/segre_decode.sv
hdl/segre_ex_stage.sv
hdl/segre_register_file.sv
hdl/segre_mmu.sv
hdl/segre_core.sv
tb/segre_tb_memory.sv
tb/segre_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= segre_core_tb
FILELIST  ?= segre_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/segre_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_core_tb;

    import segre_pkg::*;
    import segre_mem_pkg::*;

    localparam addr_t BOOT_ADDR        = 32'h0000_0080;
    localparam addr_t DATA_BASE        = 32'h0000_0100;
    localparam int    CLK_PERIOD       = 20;
    localparam int    RESET_CYCLES     = 10;
    localparam int    MAX_INSTR        = 200;
    localparam int    CYCLES_PER_INSTR = 12;
    localparam int    N_STORES         = 6;
    localparam int    TIMEOUT_NS = (RESET_CYCLES + MAX_INSTR * CYCLES_PER_INSTR) * CLK_PERIOD;

    typedef struct packed {
        addr_t            addr;
        word_t            data;
        memop_data_type_e size;
    } store_t;

    logic             clk = 1'b0;
    logic             arst_n;
    logic             mm_data_rdy;
    word_t            mm_rd_data;
    word_t            mm_wr_data;
    addr_t            mm_addr;
    addr_t            mm_wr_addr;
    logic             mm_rd;
    logic             mm_wr;
    memop_data_type_e mm_wr_type;

    store_t exp_st [N_STORES];
    int     assert_errors = 0;
    int     end_errors = 0;
    int     fetch_idx;
    int     store_idx;
    addr_t  exp_pc;
    addr_t  last_fetch;
    logic   done;
    logic   fetch_done;
    logic   store_done;
    word_t  byte_mask;

    always #(CLK_PERIOD / 2) clk = ~clk;

    segre_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) uut (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .mm_data_rdy_i     (mm_data_rdy),
        .mm_rd_data_i      (mm_rd_data),
        .mm_wr_data_o      (mm_wr_data),
        .mm_addr_o         (mm_addr),
        .mm_wr_addr_o      (mm_wr_addr),
        .mm_rd_o           (mm_rd),
        .mm_wr_o           (mm_wr),
        .mm_wr_data_type_o (mm_wr_type)
    );

    segre_tb_memory #(
        .BOOT_ADDR (BOOT_ADDR)
    ) mem (
        .clk_i      (clk),
        .rd_i       (mm_rd),
        .wr_i       (mm_wr),
        .addr_i     (mm_addr),
        .wr_addr_i  (mm_wr_addr),
        .wr_data_i  (mm_wr_data),
        .wr_type_i  (mm_wr_type),
        .data_rdy_o (mm_data_rdy),
        .rd_data_o  (mm_rd_data)
    );

    // Register values by the RV32I rules with 32-bit wraparound
    function automatic void fill_expected();
        word_t x1;
        word_t x2;
        word_t x3;
        word_t x4;
        word_t x5;
        x1 = 32'd5;
        x2 = 32'd300;
        x3 = x1 + x2;
        x4 = x1 - x2;
        x5 = x4 + 32'hffff_ffec;
        exp_st[0] = '{DATA_BASE, x3, WORD};
        exp_st[1] = '{DATA_BASE + 32'h4, x4, WORD};
        exp_st[2] = '{DATA_BASE + 32'h8, x5, WORD};
        exp_st[3] = '{DATA_BASE + 32'hc, x3 + 32'd1, WORD};
        exp_st[4] = '{DATA_BASE + 32'h10, {24'd0, x5[7:0]}, BYTE};
        exp_st[5] = '{DATA_BASE + 32'h18, x2, WORD};
    endfunction

    // Data bits that a store of the given size carries
    function automatic word_t size_mask(memop_data_type_e size);
        return (size == BYTE) ? 32'h0000_00ff : 32'hffff_ffff;
    endfunction

    // PC rule with branch offsets 0x30, 0x38 and 0x40 and their operand values
    function automatic addr_t next_pc(addr_t pc);
        logic  is_branch;
        word_t a;
        word_t b;
        word_t imm;
        is_branch = 1'b1;
        a         = '0;
        b         = '0;
        imm       = '0;
        case (pc - BOOT_ADDR)
            32'h30: begin
                a   = 32'd5;
                b   = 32'd5;
                imm = 32'd8;
            end
            32'h38: begin
                a   = 32'd5;
                b   = 32'd300;
                imm = 32'd8;
            end
            32'h40: imm = 32'd0;
            default: is_branch = 1'b0;
        endcase
        if (is_branch && a == b) begin
            return pc + imm;
        end
        return pc + 32'd4;
    endfunction

    assign fetch_done = mm_rd && mm_data_rdy && mm_addr < DATA_BASE;
    assign store_done = mm_wr && mm_data_rdy;
    assign byte_mask  = size_mask(exp_st[store_idx].size);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_idx  <= 0;
            store_idx  <= 0;
            exp_pc     <= BOOT_ADDR;
            last_fetch <= '0;
            done       <= 1'b0;
        end else begin
            if (fetch_done) begin
                fetch_idx  <= fetch_idx + 1;
                exp_pc     <= next_pc(exp_pc);
                last_fetch <= mm_addr;
                // Self loop reached
                if (fetch_idx != 0 && mm_addr == last_fetch) begin
                    done <= 1'b1;
                end
            end
            if (store_done) begin
                store_idx <= store_idx + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) !arst_n |-> !mm_rd && !mm_wr)
        else begin
            assert_errors++;
            $display("Memory strobe active during reset");
        end

    a_boot_fetch: assert property (@(posedge clk) disable iff (!arst_n)
        mm_rd && fetch_idx == 0 |-> mm_addr == BOOT_ADDR)
        else begin
            assert_errors++;
            $display("Mismatch mm_addr_o: got %h expected %h", $sampled(mm_addr), BOOT_ADDR);
        end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (mm_rd || mm_wr) && !mm_data_rdy |=>
        $stable(mm_addr) && $stable(mm_wr_data) && $stable(mm_wr_type))
        else begin
            assert_errors++;
            $display("Request changed before the memory answered");
        end

    a_req_release: assert property (@(posedge clk) disable iff (!arst_n)
        mm_data_rdy |=> !mm_rd && !mm_wr)
        else begin
            assert_errors++;
            $display("Strobe still high after its ready pulse");
        end

    a_fetch_pc: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_done |-> mm_addr == exp_pc)
        else begin
            assert_errors++;
            $display("Mismatch mm_addr_o: got %h expected %h",
                     $sampled(mm_addr), $sampled(exp_pc));
        end

    a_store_count: assert property (@(posedge clk) disable iff (!arst_n)
        store_done |-> store_idx < N_STORES)
        else begin
            assert_errors++;
            $display("Store beyond the expected sequence at %h", $sampled(mm_wr_addr));
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!arst_n)
        store_done && store_idx < N_STORES |-> mm_wr_addr == exp_st[store_idx].addr)
        else begin
            assert_errors++;
            $display("Mismatch mm_wr_addr_o: got %h expected %h",
                     $sampled(mm_wr_addr), exp_st[$sampled(store_idx)].addr);
        end

    a_store_data: assert property (@(posedge clk) disable iff (!arst_n)
        store_done && store_idx < N_STORES |->
        (mm_wr_data & byte_mask) == exp_st[store_idx].data)
        else begin
            assert_errors++;
            $display("Mismatch mm_wr_data_o: got %h expected %h",
                     $sampled(mm_wr_data), exp_st[$sampled(store_idx)].data);
        end

    a_store_size: assert property (@(posedge clk) disable iff (!arst_n)
        store_done && store_idx < N_STORES |-> mm_wr_type == exp_st[store_idx].size)
        else begin
            assert_errors++;
            $display("Mismatch mm_wr_data_type_o: got %h expected %h",
                     $sampled(mm_wr_type), exp_st[$sampled(store_idx)].size);
        end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the program reached its final loop");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        fill_expected();
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        wait (done);
        repeat (4) @(posedge clk);
        if (mem.store_log.size() != N_STORES) begin
            end_errors++;
            $display("Store log holds %0d stores, %0d expected",
                     mem.store_log.size(), N_STORES);
        end
        // Log order against the expected sequence
        for (int i = 0; i < mem.store_log.size() && i < N_STORES; i++) begin
            if (mem.store_log[i].addr != exp_st[i].addr) begin
                end_errors++;
                $display("Mismatch store_log.addr: got %h expected %h",
                         mem.store_log[i].addr, exp_st[i].addr);
            end
            if ((mem.store_log[i].data & size_mask(exp_st[i].size)) != exp_st[i].data) begin
                end_errors++;
                $display("Mismatch store_log.data: got %h expected %h",
                         mem.store_log[i].data, exp_st[i].data);
            end
        end
        $display("Errors: %0d assertion, %0d end of run; %0d stores, %0d fetches",
                 assert_errors, end_errors, mem.store_log.size(), fetch_idx);
        if (assert_errors == 0 && end_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : segre_core_tb

`default_nettype wire

/* tb/segre_tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_tb_memory #(
    parameter int               DEPTH     = 256,
    parameter segre_pkg::addr_t BOOT_ADDR = '0
) (
    input  logic                            clk_i,
    input  logic                            rd_i,
    input  logic                            wr_i,
    input  segre_pkg::addr_t                addr_i,
    input  segre_pkg::addr_t                wr_addr_i,
    input  segre_pkg::word_t                wr_data_i,
    input  segre_mem_pkg::memop_data_type_e wr_type_i,
    output logic                            data_rdy_o,
    output segre_pkg::word_t                rd_data_o
);

    import segre_pkg::*;
    import segre_mem_pkg::*;

    typedef struct packed {
        addr_t            addr;
        word_t            data;
        memop_data_type_e size;
    } store_t;

    word_t       mem [DEPTH];
    store_t      store_log [$];
    logic [31:0] lfsr;
    logic        bit_lo;
    logic        bit_hi;
    int          latency;
    word_t       wr_word;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1, reg_addr_t rd);
        return {f7, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic put(int i, word_t w);
        mem[int'(BOOT_ADDR[9:2]) + i] = w;
    endtask

    initial begin
        // Filler words carry their own index
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'ha5a5_0000 | i;
        end
        put(0, enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd1, OPC_OPIMM));
        put(1, enc_i(12'd300, 5'd0, F3_ADD_SUB, 5'd2, OPC_OPIMM));
        put(2, enc_r(F7_ADD, 5'd2, 5'd1, 5'd3));
        put(3, enc_r(F7_SUB, 5'd2, 5'd1, 5'd4));
        put(4, enc_i(12'hfec, 5'd4, F3_ADD_SUB, 5'd5, OPC_OPIMM));
        put(5, enc_s(12'h100, 5'd3, 5'd0, F3_SW));
        put(6, enc_s(12'h104, 5'd4, 5'd0, F3_SW));
        put(7, enc_s(12'h108, 5'd5, 5'd0, F3_SW));
        put(8, enc_i(12'h100, 5'd0, F3_LW, 5'd6, OPC_LOAD));
        put(9, enc_i(12'd1, 5'd6, F3_ADD_SUB, 5'd6, OPC_OPIMM));
        put(10, enc_s(12'h10c, 5'd6, 5'd0, F3_SW));
        put(11, enc_s(12'h110, 5'd5, 5'd0, F3_SB));
        // Taken branch skips the poison store
        put(12, enc_b(13'd8, 5'd1, 5'd1));
        put(13, enc_s(12'h114, 5'd1, 5'd0, F3_SW));
        put(14, enc_b(13'd8, 5'd2, 5'd1));
        put(15, enc_s(12'h118, 5'd2, 5'd0, F3_SW));
        put(16, enc_b(13'd0, 5'd0, 5'd0));
    end

    initial begin
        data_rdy_o = 1'b0;
        rd_data_o  = '0;
        lfsr       = 32'h0bd4_7120;
        forever begin
            @(negedge clk_i);
            if (rd_i || wr_i) begin
                lfsr    = lfsr_next(lfsr);
                bit_lo  = lfsr[0];
                lfsr    = lfsr_next(lfsr);
                bit_hi  = lfsr[0];
                latency = 1 + int'({bit_hi, bit_lo});
                repeat (latency) @(posedge clk_i);
                #2;
                data_rdy_o = 1'b1;
                if (rd_i) begin
                    rd_data_o = mem[addr_i[9:2]];
                end else begin
                    wr_word = mem[wr_addr_i[9:2]];
                    if (wr_type_i == BYTE) begin
                        wr_word[8*wr_addr_i[1:0] +: 8] = wr_data_i[7:0];
                    end else begin
                        wr_word = wr_data_i;
                    end
                    mem[wr_addr_i[9:2]] = wr_word;
                    store_log.push_back('{wr_addr_i, wr_data_i, wr_type_i});
                end
                @(posedge clk_i);
                #2;
                data_rdy_o = 1'b0;
            end
        end
    end

endmodule : segre_tb_memory

`default_nettype wire

/* hdl/segre_core.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_core #(
    parameter segre_pkg::addr_t BOOT_ADDR = '0
) (
    // Clock and reset
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    // Main memory
    input  logic                            mm_data_rdy_i,
    input  segre_pkg::word_t                mm_rd_data_i,
    output segre_pkg::word_t                mm_wr_data_o,
    output segre_pkg::addr_t                mm_addr_o,
    output segre_pkg::addr_t                mm_wr_addr_o,
    output logic                            mm_rd_o,
    output logic                            mm_wr_o,
    output segre_mem_pkg::memop_data_type_e mm_wr_data_type_o
);

    import segre_pkg::*;
    import segre_mem_pkg::*;

    core_fsm_state_e fsm_state;
    decoded_instr_t  dec;
    reg_addr_t       rf_raddr_a;
    reg_addr_t       rf_raddr_b;
    word_t           rf_data_a;
    word_t           rf_data_b;
    logic            rf_we;
    reg_addr_t       rf_waddr;
    word_t           rf_wdata;
    mem_req_t        mem_req;
    logic            access_strobe;
    logic            data_rdy;
    word_t           rd_data;

    segre_controller controller (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .data_rdy_i (data_rdy),
        .dec_i      (dec),
        .state_o    (fsm_state)
    );

    segre_decode decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .state_i      (fsm_state),
        .data_rdy_i   (data_rdy),
        .rd_data_i    (rd_data),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .dec_o        (dec)
    );

    segre_ex_stage #(
        .BOOT_ADDR (BOOT_ADDR)
    ) ex_stage (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .state_i         (fsm_state),
        .dec_i           (dec),
        .rf_data_a_i     (rf_data_a),
        .rf_data_b_i     (rf_data_b),
        .data_rdy_i      (data_rdy),
        .ld_data_i       (rd_data),
        .req_o           (mem_req),
        .access_strobe_o (access_strobe),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata)
    );

    segre_register_file segre_rf (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .data_w_i  (rf_wdata),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b)
    );

    segre_mmu mmu (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .req_i             (mem_req),
        .access_strobe_i   (access_strobe),
        .mm_data_rdy_i     (mm_data_rdy_i),
        .mm_rd_data_i      (mm_rd_data_i),
        .data_rdy_o        (data_rdy),
        .rd_data_o         (rd_data),
        .mm_rd_o           (mm_rd_o),
        .mm_wr_o           (mm_wr_o),
        .mm_addr_o         (mm_addr_o),
        .mm_wr_addr_o      (mm_wr_addr_o),
        .mm_wr_data_o      (mm_wr_data_o),
        .mm_wr_data_type_o (mm_wr_data_type_o)
    );

endmodule : segre_core

`default_nettype wire

/* hdl/segre_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_mmu (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  segre_mem_pkg::mem_req_t        req_i,
    input  logic                           access_strobe_i,
    input  logic                           mm_data_rdy_i,
    input  segre_pkg::word_t               mm_rd_data_i,
    output logic                           data_rdy_o,
    output segre_pkg::word_t               rd_data_o,
    output logic                           mm_rd_o,
    output logic                           mm_wr_o,
    output segre_pkg::addr_t               mm_addr_o,
    output segre_pkg::addr_t               mm_wr_addr_o,
    output segre_pkg::word_t               mm_wr_data_o,
    output segre_mem_pkg::memop_data_type_e mm_wr_data_type_o
);

    import segre_pkg::*;
    import segre_mem_pkg::*;

    mem_req_t req_q;
    logic     data_rdy_q;
    word_t    rd_data_q;

    // Request is held until the memory answers
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q      <= '0;
            data_rdy_q <= 1'b0;
        end else begin
            data_rdy_q <= mm_data_rdy_i;
            if (access_strobe_i) begin
                req_q <= req_i;
            end else if (mm_data_rdy_i) begin
                req_q.rd <= 1'b0;
                req_q.wr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mm_data_rdy_i && req_q.rd) begin
            rd_data_q <= mm_rd_data_i;
        end
    end

    assign data_rdy_o        = data_rdy_q;
    assign rd_data_o         = rd_data_q;
    assign mm_rd_o           = req_q.rd;
    assign mm_wr_o           = req_q.wr;
    assign mm_addr_o         = req_q.addr;
    assign mm_wr_addr_o      = req_q.addr;
    assign mm_wr_data_o      = req_q.data;
    assign mm_wr_data_type_o = req_q.size;

    a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (mm_rd_o || mm_wr_o) && !mm_data_rdy_i |=> $stable(mm_addr_o));

endmodule : segre_mmu

`default_nettype wire

/* hdl/segre_register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_register_file (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 we_i,
    input  segre_pkg::reg_addr_t waddr_i,
    input  segre_pkg::word_t     data_w_i,
    input  segre_pkg::reg_addr_t raddr_a_i,
    input  segre_pkg::reg_addr_t raddr_b_i,
    output segre_pkg::word_t     data_a_o,
    output segre_pkg::word_t     data_b_o
);

    import segre_pkg::*;

    word_t regs_q [2**REG_ADDR_SIZE];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_SIZE; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= data_w_i;
        end
    end

    // x0 reads as zero
    assign data_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign data_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule : segre_register_file

`default_nettype wire

/* hdl/segre_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_ex_stage #(
    parameter segre_pkg::addr_t BOOT_ADDR = '0
) (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  segre_pkg::core_fsm_state_e state_i,
    input  segre_pkg::decoded_instr_t  dec_i,
    input  segre_pkg::word_t           rf_data_a_i,
    input  segre_pkg::word_t           rf_data_b_i,
    input  logic                       data_rdy_i,
    input  segre_pkg::word_t           ld_data_i,
    output segre_mem_pkg::mem_req_t    req_o,
    output logic                       access_strobe_o,
    output logic                       rf_we_o,
    output segre_pkg::reg_addr_t       rf_waddr_o,
    output segre_pkg::word_t           rf_wdata_o
);

    import segre_pkg::*;
    import segre_mem_pkg::*;

    addr_t pc_q;
    word_t alu_b;
    word_t alu_res;
    word_t alu_q;
    logic  taken_q;
    logic  pending_q;

    assign alu_b   = dec_i.imm_sel ? dec_i.imm : rf_data_b_i;
    assign alu_res = (dec_i.alu_op == ALU_SUB) ? rf_data_a_i - alu_b : rf_data_a_i + alu_b;

    always_ff @(posedge clk_i) begin
        if (state_i == EXECUTE) begin
            alu_q <= alu_res;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= BOOT_ADDR;
            taken_q <= 1'b0;
        end else if (state_i == EXECUTE) begin
            taken_q <= dec_i.branch && (rf_data_a_i == rf_data_b_i);
        end else if (state_i == WRITEBACK) begin
            pc_q <= taken_q ? pc_q + dec_i.imm : pc_q + 32'd4;
        end
    end

    // One strobe per access, released by the ready pulse
    assign access_strobe_o = (state_i == FETCH || state_i == MEMORY) && !pending_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else if (access_strobe_o) begin
            pending_q <= 1'b1;
        end else if (data_rdy_i) begin
            pending_q <= 1'b0;
        end
    end

    always_comb begin
        req_o = '0;
        if (state_i == MEMORY) begin
            req_o.rd   = dec_i.load;
            req_o.wr   = dec_i.store;
            req_o.addr = alu_q;
            // SB data sits in the low byte
            req_o.data = dec_i.mem_byte ? word_t'(rf_data_b_i[7:0]) : rf_data_b_i;
            req_o.size = dec_i.mem_byte ? BYTE : WORD;
        end else begin
            req_o.rd   = 1'b1;
            req_o.addr = pc_q;
            req_o.size = WORD;
        end
    end

    assign rf_we_o    = (state_i == WRITEBACK) && dec_i.rf_we;
    assign rf_waddr_o = dec_i.rd;
    assign rf_wdata_o = dec_i.load ? ld_data_i : alu_q;

    a_fetch_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        access_strobe_o && state_i == FETCH |-> req_o.addr[1:0] == 2'b00);

endmodule : segre_ex_stage

`default_nettype wire

/* hdl/segre_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_decode (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  segre_pkg::core_fsm_state_e state_i,
    input  logic                       data_rdy_i,
    input  segre_pkg::word_t           rd_data_i,
    output segre_pkg::reg_addr_t       rf_raddr_a_o,
    output segre_pkg::reg_addr_t       rf_raddr_b_o,
    output segre_pkg::decoded_instr_t  dec_o
);

    import segre_pkg::*;

    word_t      ir_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;

    // Instruction register, zero decodes as a no-op
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ir_q <= '0;
        end else if (state_i == FETCH && data_rdy_i) begin
            ir_q <= rd_data_i;
        end
    end

    assign opcode = ir_q[6:0];
    assign funct3 = ir_q[14:12];
    assign funct7 = ir_q[31:25];

    assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
    assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
    assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};

    assign rf_raddr_a_o = ir_q[19:15];
    assign rf_raddr_b_o = ir_q[24:20];

    always_comb begin
        dec_o    = '0;
        dec_o.rd = ir_q[11:7];
        case (opcode)
            OPC_OP: begin
                if (funct3 == F3_ADD_SUB && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
                    dec_o.rf_we  = 1'b1;
                    dec_o.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                end
            end
            OPC_OPIMM: begin
                if (funct3 == F3_ADD_SUB) begin
                    dec_o.rf_we   = 1'b1;
                    dec_o.imm_sel = 1'b1;
                    dec_o.imm     = imm_i;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_LW) begin
                    dec_o.load    = 1'b1;
                    dec_o.rf_we   = 1'b1;
                    dec_o.imm_sel = 1'b1;
                    dec_o.imm     = imm_i;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_SW || funct3 == F3_SB) begin
                    dec_o.store    = 1'b1;
                    dec_o.imm_sel  = 1'b1;
                    dec_o.imm      = imm_s;
                    dec_o.mem_byte = (funct3 == F3_SB);
                end
            end
            OPC_BRANCH: begin
                if (funct3 == F3_BEQ) begin
                    dec_o.branch = 1'b1;
                    dec_o.imm    = imm_b;
                end
            end
            default: ;
        endcase
    end

    a_ld_st_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(dec_o.load && dec_o.store));

endmodule : segre_decode

`default_nettype wire

/* hdl/segre_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module segre_controller (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       data_rdy_i,
    input  segre_pkg::decoded_instr_t  dec_i,
    output segre_pkg::core_fsm_state_e state_o
);

    import segre_pkg::*;

    core_fsm_state_e state_q;
    core_fsm_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Memory latency holds the core here
            FETCH: begin
                if (data_rdy_i) begin
                    state_d = DECODE;
                end
            end
            DECODE: state_d = EXECUTE;
            EXECUTE: begin
                if (dec_i.load || dec_i.store) begin
                    state_d = MEMORY;
                end else begin
                    state_d = WRITEBACK;
                end
            end
            MEMORY: begin
                if (data_rdy_i) begin
                    state_d = WRITEBACK;
                end
            end
            WRITEBACK: state_d = FETCH;
            default: state_d = FETCH;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    a_legal_state: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        state_q inside {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK});

endmodule : segre_controller

`default_nettype wire

/* hdl/segre_mem_pkg.sv */
`default_nettype none

package segre_mem_pkg;

    // Encoding leaves room for a halfword size
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        WORD = 2'b10
    } memop_data_type_e;

    typedef struct packed {
        logic              rd;
        logic              wr;
        segre_pkg::addr_t  addr;
        segre_pkg::word_t  data;
        memop_data_type_e  size;
    } mem_req_t;

endpackage : segre_mem_pkg

`default_nettype wire

/* hdl/segre_pkg.sv */
`default_nettype none

package segre_pkg;

    localparam int WORD_SIZE     = 32;
    localparam int ADDR_SIZE     = 32;
    localparam int REG_ADDR_SIZE = 5;

    typedef logic [WORD_SIZE-1:0]     word_t;
    typedef logic [ADDR_SIZE-1:0]     addr_t;
    typedef logic [REG_ADDR_SIZE-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } core_fsm_state_e;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_opcode_e;

    // RV32I opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;

    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        alu_opcode_e alu_op;
        logic        imm_sel;
        logic        rf_we;
        reg_addr_t   rd;
        logic        load;
        logic        store;
        logic        branch;
        logic        mem_byte;  // Byte access, word otherwise
        word_t       imm;
    } decoded_instr_t;

endpackage : segre_pkg

`default_nettype wire
